/* hw/rxReqPkg.sv */
package rxReqPkg;

    // Beat and field widths
    localparam int dataWidth   = 128;
    localparam int dwPerBeat   = dataWidth / 32;
    localparam int offsetWidth = $clog2(dwPerBeat);
    localparam int hdrWidth    = 128;
    localparam int addrWidth   = 64;
    localparam int barWidth    = 8;

    // Register stages ahead of the output register
    localparam int inputStages = 1;
    localparam int hdrStages   = 1;
    localparam int compStages  = 1;
    localparam int pipeStages  = inputStages + hdrStages + compStages;

    // TLP type field of MRd and MWr
    localparam logic [4:0] typeMemReq = 5'd0;

    // Request type codes on the output
    localparam logic [1:0] reqTypeRead  = 2'd0;
    localparam logic [1:0] reqTypeWrite = 2'd1;

    // Header DW0 sits in bits 31:0, fmt[0] selects the member
    typedef union packed {
        struct packed {
            logic [31:0] unused;
            logic [31:0] addr;
            logic [15:0] requesterId;
            logic [7:0]  tag;
            logic [3:0]  lastBe;
            logic [3:0]  firstBe;
            logic [2:0]  fmt;
            logic [4:0]  tlpType;
            logic        rsvd0;
            logic [2:0]  tc;
            logic [3:0]  rsvd1;
            logic        digest;
            logic        ep;
            logic [1:0]  attr;
            logic [1:0]  rsvd2;
            logic [9:0]  length;
        } hdr3Dw;
        struct packed {
            logic [31:0] addrLo;
            logic [31:0] addrHi;
            logic [15:0] requesterId;
            logic [7:0]  tag;
            logic [3:0]  lastBe;
            logic [3:0]  firstBe;
            logic [2:0]  fmt;
            logic [4:0]  tlpType;
            logic        rsvd0;
            logic [2:0]  tc;
            logic [3:0]  rsvd1;
            logic        digest;
            logic        ep;
            logic [1:0]  attr;
            logic [1:0]  rsvd2;
            logic [9:0]  length;
        } hdr4Dw;
    } tlpHdrT;

endpackage

/* hw/rxBusIfs.sv */
`timescale 1ns/10ps

// One beat of the receive stream at some pipeline stage
interface rxBeatIf;
    import rxReqPkg::*;

    logic [dataWidth-1:0]   data;
    logic                   valid;
    logic                   startFlag;
    logic                   endFlag;
    logic [offsetWidth-1:0] endOffset;
    logic [barWidth-1:0]    barDecode;

    modport producer (output data, valid, startFlag, endFlag, endOffset, barDecode);
    modport consumer (input  data, valid, startFlag, endFlag, endOffset, barDecode);
endinterface

// Header and framing of the beat in the header stage
interface hdrInfoIf;
    import rxReqPkg::*;

    tlpHdrT                 hdr;
    logic                   startFlag;
    logic [offsetWidth-1:0] startOffset;
    logic                   endFlag;
    logic [offsetWidth-1:0] endOffset;
    logic                   inRequest;
    logic [barWidth-1:0]    barDecode;
    logic                   midPacket;

    modport producer (output hdr, startFlag, startOffset, endFlag, endOffset, inRequest,
                      barDecode, midPacket);
    modport consumer (input  hdr, startFlag, startOffset, endFlag, endOffset, inRequest,
                      barDecode, midPacket);
endinterface

// Decoded request metadata ahead of the output register
interface rxrMetaIf;
    import rxReqPkg::*;

    logic [3:0]             fdwbe;
    logic [3:0]             ldwbe;
    logic [2:0]             tc;
    logic [1:0]             attr;
    logic [7:0]             tag;
    logic [1:0]             reqType;
    logic [addrWidth-1:0]   addr;
    logic [barWidth-1:0]    barDecoded;
    logic [15:0]            requesterId;
    logic [9:0]             length;
    logic                   ep;
    logic [dwPerBeat-1:0]   wordEnable;
    logic                   startFlag;
    logic [offsetWidth-1:0] startOffset;
    logic                   endFlag;
    logic                   valid;

    modport producer (output fdwbe, ldwbe, tc, attr, tag, reqType, addr, barDecoded,
                      requesterId, length, ep, wordEnable, startFlag, startOffset,
                      endFlag, valid);
    modport consumer (input  fdwbe, ldwbe, tc, attr, tag, reqType, addr, barDecoded,
                      requesterId, length, ep, wordEnable, startFlag, startOffset,
                      endFlag, valid);
endinterface

/* hw/rxBeatDelay.sv */
`timescale 1ns/10ps

module rxBeatDelay (
    input  logic                             CLK,
    input  logic                             rstN,
    input  logic [rxReqPkg::dataWidth-1:0]   rxData,
    input  logic                             rxValid,
    input  logic                             rxStartFlag,
    input  logic                             rxEndFlag,
    input  logic [rxReqPkg::offsetWidth-1:0] rxEndOffset,
    input  logic [rxReqPkg::barWidth-1:0]    rxBarDecode,
    rxBeatIf.producer                        hdrTap,
    rxBeatIf.producer                        outTap
);
    import rxReqPkg::*;

    logic [dataWidth-1:0]   dataQ      [pipeStages];
    logic [offsetWidth-1:0] endOffsetQ [pipeStages];
    logic [barWidth-1:0]    barQ       [pipeStages];
    logic [pipeStages-1:0]  validQ;
    logic [pipeStages-1:0]  startQ;
    logic [pipeStages-1:0]  endQ;

    // Flags are qualified by valid once, at the input stage
    always_ff @(posedge CLK) begin
        if (!rstN) begin
            validQ <= '0;
            startQ <= '0;
            endQ   <= '0;
        end else begin
            validQ <= {validQ[pipeStages-2:0], rxValid};
            startQ <= {startQ[pipeStages-2:0], rxValid & rxStartFlag};
            endQ   <= {endQ[pipeStages-2:0], rxValid & rxEndFlag};
        end
    end

    always_ff @(posedge CLK) begin
        dataQ[0]      <= rxData;
        endOffsetQ[0] <= rxEndOffset;
        barQ[0]       <= rxBarDecode;
        for (int i = 1; i < pipeStages; i++) begin
            dataQ[i]      <= dataQ[i-1];
            endOffsetQ[i] <= endOffsetQ[i-1];
            barQ[i]       <= barQ[i-1];
        end
    end

    // Header stage tap
    assign hdrTap.data      = dataQ[inputStages];
    assign hdrTap.valid     = validQ[inputStages];
    assign hdrTap.startFlag = startQ[inputStages];
    assign hdrTap.endFlag   = endQ[inputStages];
    assign hdrTap.endOffset = endOffsetQ[inputStages];
    assign hdrTap.barDecode = barQ[inputStages];

    // Last stage, lines up with the computation register
    assign outTap.data      = dataQ[pipeStages-1];
    assign outTap.valid     = validQ[pipeStages-1];
    assign outTap.startFlag = startQ[pipeStages-1];
    assign outTap.endFlag   = endQ[pipeStages-1];
    assign outTap.endOffset = endOffsetQ[pipeStages-1];
    assign outTap.barDecode = barQ[pipeStages-1];

endmodule

/* hw/rxHdrCapture.sv */
`timescale 1ns/10ps

module rxHdrCapture (
    input  logic       CLK,
    input  logic       rstN,
    rxBeatIf.consumer  beat,
    hdrInfoIf.producer info
);
    import rxReqPkg::*;

    tlpHdrT              hdrReg;
    tlpHdrT              hdrCur;
    logic [barWidth-1:0] barReg;
    logic                delayedSop;
    logic                reqOpen;
    logic                is4Dw;
    logic                hasData;
    logic                isMemReq;
    logic                startFlag;
    logic                inRequest;

    // Start beat decodes straight from the tap, later beats from the held copy
    assign hdrCur = beat.startFlag ? tlpHdrT'(beat.data[hdrWidth-1:0]) : hdrReg;

    assign is4Dw    = hdrCur.hdr3Dw.fmt[0];
    assign hasData  = hdrCur.hdr3Dw.fmt[1];
    assign isMemReq = (hdrCur.hdr3Dw.tlpType == typeMemReq);

    // 3DW and 4DW without payload flag the header beat
    // 4DW with payload fills the header beat, so data starts one beat later
    assign startFlag = (beat.startFlag & ~(is4Dw & hasData)) | (delayedSop & beat.valid);

    // Request spans from its data start through its end beat
    assign inRequest = (startFlag & isMemReq & ~beat.endFlag) | reqOpen;

    always_ff @(posedge CLK) begin
        if (beat.startFlag) begin
            hdrReg <= hdrCur;
            barReg <= beat.barDecode;
        end
    end

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            delayedSop <= 1'b0;
            reqOpen    <= 1'b0;
        end else if (beat.valid) begin
            delayedSop <= beat.startFlag & is4Dw & hasData;
            reqOpen    <= inRequest & ~beat.endFlag;
        end
    end

    assign info.hdr         = hdrCur;
    assign info.startFlag   = startFlag;
    // Data follows a 3DW header at DW3, a 4DW header leaves DW0
    assign info.startOffset = {offsetWidth{~is4Dw}};
    assign info.endFlag     = beat.endFlag;
    assign info.endOffset   = beat.endOffset;
    assign info.inRequest   = inRequest;
    assign info.barDecode   = beat.startFlag ? beat.barDecode : barReg;
    assign info.midPacket   = reqOpen;

    // An opened request sees no new start beat up to and including its end
    assert property (@(posedge CLK) disable iff (!rstN)
        (startFlag && isMemReq && !beat.endFlag) |=>
            (!beat.startFlag until_with beat.endFlag))
    else $error("start beat inside an open memory request");

endmodule

/* hw/rxMetaDecode.sv */
`timescale 1ns/10ps

module rxMetaDecode (
    input  logic       CLK,
    input  logic       rstN,
    hdrInfoIf.consumer info,
    rxrMetaIf.producer meta
);
    import rxReqPkg::*;

    logic                 isMemReq;
    logic                 singleCycle;
    logic [dwPerBeat-1:0] startMask;
    logic [dwPerBeat-1:0] endMask;
    logic [addrWidth-1:0] addr;

    assign isMemReq    = (info.hdr.hdr3Dw.tlpType == typeMemReq);
    assign singleCycle = info.startFlag & info.endFlag & isMemReq & ~info.midPacket;

    // Start mask drops DWs below the start offset
    assign startMask = info.startFlag ? ({dwPerBeat{1'b1}} << info.startOffset) : '1;
    // End mask keeps DW0 through the end offset
    assign endMask = info.endFlag ? ({dwPerBeat{1'b1}} >> (dwPerBeat - 1 - info.endOffset))
                                  : '1;

    // 3DW carries a 32-bit address in DW2, 4DW splits it over DW2 and DW3
    assign addr = info.hdr.hdr3Dw.fmt[0] ?
                  {info.hdr.hdr4Dw.addrHi, info.hdr.hdr4Dw.addrLo} :
                  {{(addrWidth/2){1'b0}}, info.hdr.hdr3Dw.addr};

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            meta.valid <= 1'b0;
        end else begin
            meta.valid <= info.inRequest | singleCycle;
        end
    end

    always_ff @(posedge CLK) begin
        meta.fdwbe       <= info.hdr.hdr3Dw.firstBe;
        meta.ldwbe       <= info.hdr.hdr3Dw.lastBe;
        meta.tc          <= info.hdr.hdr3Dw.tc;
        meta.attr        <= info.hdr.hdr3Dw.attr;
        meta.tag         <= info.hdr.hdr3Dw.tag;
        meta.reqType     <= info.hdr.hdr3Dw.fmt[1] ? reqTypeWrite : reqTypeRead;
        meta.addr        <= addr;
        meta.barDecoded  <= info.barDecode;
        meta.requesterId <= info.hdr.hdr3Dw.requesterId;
        meta.length      <= info.hdr.hdr3Dw.length;
        meta.ep          <= info.hdr.hdr3Dw.ep;
        meta.wordEnable  <= startMask & endMask;
        meta.startFlag   <= info.startFlag;
        meta.startOffset <= info.startOffset;
        meta.endFlag     <= info.endFlag;
    end

endmodule

/* hw/rxOutputStage.sv */
`timescale 1ns/10ps

module rxOutputStage (
    input  logic                             CLK,
    input  logic                             rstN,
    rxrMetaIf.consumer                       meta,
    rxBeatIf.consumer                        tap,
    output logic [rxReqPkg::dataWidth-1:0]   rxrData,
    output logic                             rxrValid,
    output logic [rxReqPkg::dwPerBeat-1:0]   rxrWordEnable,
    output logic                             rxrStartFlag,
    output logic [rxReqPkg::offsetWidth-1:0] rxrStartOffset,
    output logic                             rxrEndFlag,
    output logic [rxReqPkg::offsetWidth-1:0] rxrEndOffset,
    output logic [3:0]                       rxrFdwbe,
    output logic [3:0]                       rxrLdwbe,
    output logic [2:0]                       rxrTc,
    output logic [1:0]                       rxrAttr,
    output logic [7:0]                       rxrTag,
    output logic [1:0]                       rxrType,
    output logic [rxReqPkg::addrWidth-1:0]   rxrAddr,
    output logic [rxReqPkg::barWidth-1:0]    rxrBarDecoded,
    output logic [15:0]                      rxrRequesterId,
    output logic [9:0]                       rxrLength,
    output logic                             rxrEp
);
    import rxReqPkg::*;

    always_ff @(posedge CLK) begin
        if (!rstN) begin
            rxrValid      <= 1'b0;
            rxrWordEnable <= '0;
        end else begin
            rxrValid      <= meta.valid;
            rxrWordEnable <= meta.wordEnable & {dwPerBeat{meta.valid}};
        end
    end

    // Payload and metadata, qualified by rxrValid
    always_ff @(posedge CLK) begin
        rxrData        <= tap.data;
        rxrEndOffset   <= tap.endOffset;
        rxrStartFlag   <= meta.startFlag;
        rxrStartOffset <= meta.startOffset;
        rxrEndFlag     <= meta.endFlag;
        rxrFdwbe       <= meta.fdwbe;
        rxrLdwbe       <= meta.ldwbe;
        rxrTc          <= meta.tc;
        rxrAttr        <= meta.attr;
        rxrTag         <= meta.tag;
        rxrType        <= meta.reqType;
        rxrAddr        <= meta.addr;
        rxrBarDecoded  <= meta.barDecoded;
        rxrRequesterId <= meta.requesterId;
        rxrLength      <= meta.length;
        rxrEp          <= meta.ep;
    end

    // Enabled words belong to a valid request and line up with a valid payload beat
    assert property (@(posedge CLK) disable iff (!rstN)
        (|rxrWordEnable) |-> (rxrValid && $past(tap.valid)))
    else $error("word enable without a valid payload beat");

endmodule

/* hw/rxReqEngine.sv */
`timescale 1ns/10ps

module rxReqEngine (
    input  logic                             CLK,
    input  logic                             rstN,
    input  logic [rxReqPkg::dataWidth-1:0]   rxData,
    input  logic                             rxValid,
    input  logic                             rxStartFlag,
    input  logic                             rxEndFlag,
    input  logic [rxReqPkg::offsetWidth-1:0] rxEndOffset,
    input  logic [rxReqPkg::barWidth-1:0]    rxBarDecode,
    output logic [rxReqPkg::dataWidth-1:0]   rxrData,
    output logic                             rxrValid,
    output logic [rxReqPkg::dwPerBeat-1:0]   rxrWordEnable,
    output logic                             rxrStartFlag,
    output logic [rxReqPkg::offsetWidth-1:0] rxrStartOffset,
    output logic                             rxrEndFlag,
    output logic [rxReqPkg::offsetWidth-1:0] rxrEndOffset,
    output logic [3:0]                       rxrFdwbe,
    output logic [3:0]                       rxrLdwbe,
    output logic [2:0]                       rxrTc,
    output logic [1:0]                       rxrAttr,
    output logic [7:0]                       rxrTag,
    output logic [1:0]                       rxrType,
    output logic [rxReqPkg::addrWidth-1:0]   rxrAddr,
    output logic [rxReqPkg::barWidth-1:0]    rxrBarDecoded,
    output logic [15:0]                      rxrRequesterId,
    output logic [9:0]                       rxrLength,
    output logic                             rxrEp
);

    // Beat taps out of the delay line
    rxBeatIf  hdrTap ();
    rxBeatIf  outTap ();
    hdrInfoIf info ();
    rxrMetaIf meta ();

    // Input, header and computation stages of the raw beat
    rxBeatDelay rxBeatDelay_inst (
        .*
    );

    rxHdrCapture rxHdrCapture_inst (
        .beat (hdrTap),
        .*
    );

    rxMetaDecode rxMetaDecode_inst (
        .*
    );

    rxOutputStage rxOutputStage_inst (
        .tap (outTap),
        .*
    );

endmodule

/* test/tbRxReqEngine.sv */
`timescale 1ns/10ps

module tbRxReqEngine;
    import rxReqPkg::*;

    localparam int clkHalf     = 10;
    localparam int resetCycles = 4;
    localparam int numPackets  = 200;
    localparam int maxBeats    = 5;
    localparam int maxGap      = 7;
    localparam int randSeed    = 95313;
    // Longest packets with longest gaps, doubled, plus reset and flush
    localparam int timeoutCycles = 2 * numPackets * (maxBeats + maxGap) + 200;
    // Driving edge, sampling edge and three stages
    localparam int expDepth    = 4;

    typedef struct packed {
        logic                   valid;
        logic [dwPerBeat-1:0]   wordEnable;
        logic                   startFlag;
        logic [offsetWidth-1:0] startOffset;
        logic                   endFlag;
        logic [offsetWidth-1:0] endOffset;
        logic [dataWidth-1:0]   data;
        logic [3:0]             fdwbe;
        logic [3:0]             ldwbe;
        logic [2:0]             tc;
        logic [1:0]             attr;
        logic [7:0]             tag;
        logic [1:0]             reqType;
        logic [addrWidth-1:0]   addr;
        logic [barWidth-1:0]    bar;
        logic [15:0]            requesterId;
        logic [9:0]             length;
        logic                   ep;
    } expBeatT;

    logic                   CLK;
    logic                   rstN;
    logic [dataWidth-1:0]   rxData;
    logic                   rxValid;
    logic                   rxStartFlag;
    logic                   rxEndFlag;
    logic [offsetWidth-1:0] rxEndOffset;
    logic [barWidth-1:0]    rxBarDecode;
    logic [dataWidth-1:0]   rxrData;
    logic                   rxrValid;
    logic [dwPerBeat-1:0]   rxrWordEnable;
    logic                   rxrStartFlag;
    logic [offsetWidth-1:0] rxrStartOffset;
    logic                   rxrEndFlag;
    logic [offsetWidth-1:0] rxrEndOffset;
    logic [3:0]             rxrFdwbe;
    logic [3:0]             rxrLdwbe;
    logic [2:0]             rxrTc;
    logic [1:0]             rxrAttr;
    logic [7:0]             rxrTag;
    logic [1:0]             rxrType;
    logic [addrWidth-1:0]   rxrAddr;
    logic [barWidth-1:0]    rxrBarDecoded;
    logic [15:0]            rxrRequesterId;
    logic [9:0]             rxrLength;
    logic                   rxrEp;

    expBeatT expQ[$];
    expBeatT want;
    logic    checkOn;
    logic    quietWin;
    logic    onBeat;
    int      cycles = 0;
    int      failCount = 0;

    rxReqEngine rxReqEngine_inst (.*);

    assign onBeat = checkOn && want.valid;

    initial CLK = 1'b0;
    always #(clkHalf) CLK = ~CLK;

    always @(posedge CLK) begin
        cycles <= cycles + 1;
        if (cycles >= timeoutCycles) begin
            $display("Timeout after %0d cycles, stimulus never finished", cycles);
            $display("TEST RESULT: FAIL");
            $fatal(1, "simulation timeout");
        end
    end

    task automatic reportMismatch(input string name, input logic [dataWidth-1:0] got,
                                  input logic [dataWidth-1:0] exp);
        failCount++;
        $display("** Error at %0t: %s is %0h, expected %0h", $time, name, got, exp);
        $display("TEST RESULT: FAIL");
        $fatal(1, "%s mismatch", name);
    endtask

    // Retire the oldest expectation, queue this beat's one
    task automatic driveBeat(input logic valid, input logic start, input logic last,
                             input logic [offsetWidth-1:0] endOff,
                             input logic [dataWidth-1:0] data,
                             input logic [barWidth-1:0] bar, input expBeatT e);
        @(posedge CLK);
        want = expQ.pop_front();
        expQ.push_back(e);
        rxValid     <= valid;
        rxStartFlag <= start;
        rxEndFlag   <= last;
        rxEndOffset <= endOff;
        rxData      <= data;
        rxBarDecode <= bar;
    endtask

    task automatic idleBeat();
        expBeatT e;
        e = '0;
        driveBeat(1'b0, 1'b0, 1'b0, 2'($urandom()),
                  {$urandom(), $urandom(), $urandom(), $urandom()}, 8'($urandom()), e);
    endtask

    // kind 0 completion, 1 memory read, 2 memory write
    task automatic sendPacket(input int kind, input logic is4Dw, input int len);
        logic [31:0]            dw0;
        logic [31:0]            dw1;
        logic [31:0]            addrHi;
        logic [31:0]            addrLo;
        logic [dataWidth-1:0]   hdr;
        logic [dataWidth-1:0]   data;
        logic [barWidth-1:0]    bar;
        logic [offsetWidth-1:0] endOff;
        logic                   hasData;
        logic                   hdr4;
        expBeatT                base;
        expBeatT                e;
        int                     totalDw;
        int                     beats;
        int                     dataBeat;

        hasData = (kind != 1);
        // Completions always go out as 3DW CplD
        hdr4    = is4Dw && (kind != 0);
        dw0     = $urandom();
        dw1     = $urandom();
        addrHi  = $urandom();
        addrLo  = $urandom();
        bar     = 8'($urandom());
        dw0[31:29] = {1'b0, hasData, hdr4};
        dw0[28:24] = (kind == 0) ? 5'b01010 : 5'b00000;
        dw0[9:0]   = 10'(len);
        hdr = hdr4 ? {addrLo, addrHi, dw1, dw0} : {32'h0, addrLo, dw1, dw0};

        totalDw  = (hdr4 ? 4 : 3) + (hasData ? len : 0);
        beats    = (totalDw + 3) / 4;
        dataBeat = (hdr4 && hasData) ? 1 : 0;

        base             = '0;
        base.startOffset = hdr4 ? 2'd0 : 2'd3;
        base.fdwbe       = dw1[3:0];
        base.ldwbe       = dw1[7:4];
        base.tag         = dw1[15:8];
        base.requesterId = dw1[31:16];
        base.tc          = dw0[22:20];
        base.attr        = dw0[13:12];
        base.ep          = dw0[14];
        base.length      = 10'(len);
        base.reqType     = (kind == 2) ? reqTypeWrite : reqTypeRead;
        base.addr        = hdr4 ? {addrHi, addrLo} : {32'h0, addrLo};
        base.bar         = bar;

        for (int b = 0; b < beats; b++) begin
            data = {$urandom(), $urandom(), $urandom(), $urandom()};
            // 3DW header leaves DW3 of the first beat to payload
            if (b == 0) begin
                data = hdr4 ? hdr : {data[127:96], hdr[95:0]};
            end
            endOff      = (b == beats - 1) ? 2'((totalDw - 1) % 4) : 2'($urandom());
            e           = base;
            e.valid     = (kind != 0) && (b >= dataBeat);
            e.startFlag = (b == dataBeat);
            e.endFlag   = (b == beats - 1);
            e.endOffset = endOff;
            e.data      = data;
            for (int w = 0; w < dwPerBeat; w++) begin
                e.wordEnable[w] = e.valid && (!e.startFlag || w >= e.startOffset)
                                  && (!e.endFlag || w <= endOff);
            end
            driveBeat(1'b1, b == 0, e.endFlag, endOff, data,
                      (b == 0) ? bar : 8'($urandom()), e);
        end
    endtask

    // Reset and the first cycles after it stay quiet
    assert property (@(posedge CLK) checkOn && quietWin |-> !rxrValid)
        else reportMismatch("rxrValid", $sampled(rxrValid), 0);
    assert property (@(posedge CLK) checkOn && quietWin |-> rxrWordEnable == '0)
        else reportMismatch("rxrWordEnable", $sampled(rxrWordEnable), 0);

    assert property (@(posedge CLK) checkOn |-> rxrValid == want.valid)
        else reportMismatch("rxrValid", $sampled(rxrValid), $sampled(want.valid));
    assert property (@(posedge CLK) checkOn |-> rxrWordEnable == want.wordEnable)
        else reportMismatch("rxrWordEnable", $sampled(rxrWordEnable),
                            $sampled(want.wordEnable));

    // Framing and payload of each valid beat
    assert property (@(posedge CLK) onBeat |-> rxrStartFlag == want.startFlag)
        else reportMismatch("rxrStartFlag", $sampled(rxrStartFlag), $sampled(want.startFlag));
    assert property (@(posedge CLK) onBeat && want.startFlag |->
                     rxrStartOffset == want.startOffset)
        else reportMismatch("rxrStartOffset", $sampled(rxrStartOffset),
                            $sampled(want.startOffset));
    assert property (@(posedge CLK) onBeat |-> rxrEndFlag == want.endFlag)
        else reportMismatch("rxrEndFlag", $sampled(rxrEndFlag), $sampled(want.endFlag));
    assert property (@(posedge CLK) onBeat |-> rxrEndOffset == want.endOffset)
        else reportMismatch("rxrEndOffset", $sampled(rxrEndOffset), $sampled(want.endOffset));
    assert property (@(posedge CLK) onBeat |-> rxrData == want.data)
        else reportMismatch("rxrData", $sampled(rxrData), $sampled(want.data));

    // Header fields
    assert property (@(posedge CLK) onBeat |-> rxrFdwbe == want.fdwbe)
        else reportMismatch("rxrFdwbe", $sampled(rxrFdwbe), $sampled(want.fdwbe));
    assert property (@(posedge CLK) onBeat |-> rxrLdwbe == want.ldwbe)
        else reportMismatch("rxrLdwbe", $sampled(rxrLdwbe), $sampled(want.ldwbe));
    assert property (@(posedge CLK) onBeat |-> rxrTc == want.tc)
        else reportMismatch("rxrTc", $sampled(rxrTc), $sampled(want.tc));
    assert property (@(posedge CLK) onBeat |-> rxrAttr == want.attr)
        else reportMismatch("rxrAttr", $sampled(rxrAttr), $sampled(want.attr));
    assert property (@(posedge CLK) onBeat |-> rxrTag == want.tag)
        else reportMismatch("rxrTag", $sampled(rxrTag), $sampled(want.tag));
    assert property (@(posedge CLK) onBeat |-> rxrType == want.reqType)
        else reportMismatch("rxrType", $sampled(rxrType), $sampled(want.reqType));
    assert property (@(posedge CLK) onBeat |-> rxrAddr == want.addr)
        else reportMismatch("rxrAddr", $sampled(rxrAddr), $sampled(want.addr));
    assert property (@(posedge CLK) onBeat |-> rxrBarDecoded == want.bar)
        else reportMismatch("rxrBarDecoded", $sampled(rxrBarDecoded), $sampled(want.bar));
    assert property (@(posedge CLK) onBeat |-> rxrRequesterId == want.requesterId)
        else reportMismatch("rxrRequesterId", $sampled(rxrRequesterId),
                            $sampled(want.requesterId));
    assert property (@(posedge CLK) onBeat |-> rxrLength == want.length)
        else reportMismatch("rxrLength", $sampled(rxrLength), $sampled(want.length));
    assert property (@(posedge CLK) onBeat |-> rxrEp == want.ep)
        else reportMismatch("rxrEp", $sampled(rxrEp), $sampled(want.ep));

    initial begin
        int seedValue;
        int kind;
        int len;
        int gap;
        logic is4Dw;

        seedValue   = $urandom(randSeed);
        rstN        = 1'b0;
        rxData      = '0;
        rxValid     = 1'b0;
        rxStartFlag = 1'b0;
        rxEndFlag   = 1'b0;
        rxEndOffset = '0;
        rxBarDecode = '0;
        checkOn     = 1'b0;
        quietWin    = 1'b1;
        want        = '0;
        // Idle beats already in flight at time zero
        repeat (expDepth) expQ.push_back('0);

        for (int i = 0; i < resetCycles; i++) begin
            idleBeat();
            checkOn = 1'b1;
        end
        rstN <= 1'b1;
        repeat (3) idleBeat();
        quietWin = 1'b0;

        for (int p = 0; p < numPackets; p++) begin
            kind  = $urandom_range(0, 9);
            kind  = (kind < 2) ? 0 : ((kind < 6) ? 1 : 2);
            is4Dw = 1'($urandom_range(0, 1));
            len   = $urandom_range(1, 12);
            sendPacket(kind, is4Dw, len);
            gap = $urandom_range(0, maxGap);
            repeat (gap) idleBeat();
        end
        // Flush the last packet out of the pipeline
        repeat (2 * expDepth) idleBeat();

        if (failCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* rxReqEngine.f */
hw/rxReqPkg.sv
hw/rxBusIfs.sv
hw/rxBeatDelay.sv
hw/rxHdrCapture.sv
hw/rxMetaDecode.sv
hw/rxOutputStage.sv
hw/rxReqEngine.sv
test/tbRxReqEngine.sv
